// File: common/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// Byte address width
`define FE_ADDR_W 32

// ROB index width, 32 entries
`define FE_ROB_W 5

// Instruction memory size in 32-bit words
`define FE_IMEM_WORDS 256

// Default decode queue depth
`define FE_IQ_DEPTH 4

// PC after reset
`define FE_BOOT_VECTOR 32'h0000_0100

`endif

// File: common/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

    typedef logic [`FE_ADDR_W-1:0] t_paddr;
    typedef logic [`FE_ROB_W-1:0] t_rob_id;
    typedef logic [31:0] t_instr;

    // Word index into the instruction memory
    typedef logic [$clog2(`FE_IMEM_WORDS)-1:0] t_imem_idx;

    // Mispredict reported by execute
    typedef struct packed {
        logic    valid;
        t_rob_id robid;
        t_paddr  target_addr;
    } t_br_mispred_pkt;

    // Nuke from retire, room to add fields later
    typedef struct packed {
        logic valid;
    } t_nuke_pkt;

    // Qualified redirect into the fetch controller
    typedef struct packed {
        logic   valid;
        t_paddr target_addr;
    } t_redirect;

    typedef struct packed {
        logic   valid;
        t_paddr addr;
    } t_fe_req;

    typedef struct packed {
        logic   valid;
        t_instr instr;
        t_paddr pc;
    } t_fe_rsp;

    // Memory load port
    typedef struct packed {
        logic      valid;
        t_imem_idx addr;
        t_instr    data;
    } t_imem_wr;

    typedef struct packed {
        t_instr instr;
        t_paddr pc;
    } t_instr_pkt;

endpackage

// File: src/fe_redirect.sv
`timescale 1ns/1ns

module fe_redirect
    import fe_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  t_br_mispred_pkt br_mispred,
    input  t_nuke_pkt       nuke,
    input  t_rob_id         oldest_robid,
    output t_redirect       redir,
    output logic            flush,
    output logic            nuke_pdg
);

    logic    mispred_ql;
    logic    redir_valid;
    t_paddr  redir_target;
    t_rob_id pdg_robid;

    // Age is the distance from the oldest ROB entry, wrapping with the ROB
    function automatic logic robid_older(t_rob_id a, t_rob_id b, t_rob_id oldest);
        t_rob_id dist_a;
        t_rob_id dist_b;
        dist_a = a - oldest;
        dist_b = b - oldest;
        return dist_a < dist_b;
    endfunction

    // First mispredict wins, later ones only if older than the stored one
    assign mispred_ql = br_mispred.valid &
                        (~nuke_pdg | robid_older(br_mispred.robid, pdg_robid, oldest_robid));

    // The pending flag also serves as the pending-nuke level for fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            nuke_pdg    <= 1'b0;
            redir_valid <= 1'b0;
            flush       <= 1'b0;
        end else begin
            nuke_pdg    <= ~nuke.valid & (nuke_pdg | br_mispred.valid);
            redir_valid <= mispred_ql;
            flush       <= mispred_ql | nuke.valid;
        end
    end

    // Robid and target of the oldest mispredict so far
    always_ff @(posedge clk) begin
        if (mispred_ql) begin
            pdg_robid    <= br_mispred.robid;
            redir_target <= br_mispred.target_addr;
        end
    end

    always_comb begin
        redir.valid       = redir_valid;
        redir.target_addr = redir_target;
    end

endmodule

// File: fe/fe_ctl.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fe_ctl
    import fe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  t_redirect  redir,
    input  logic       nuke_pdg,
    input  logic       resume_fetch,
    output t_fe_req    req,
    input  t_fe_rsp    rsp,
    input  logic       full,
    output logic       push,
    output t_instr_pkt push_data
);

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_REQ_IC,
        FE_WAIT_RSP,
        FE_PDG_NUKE
    } t_fe_state;

    t_fe_state state;
    t_fe_state state_nxt;
    t_paddr    pc;
    t_paddr    pc_nxt;
    logic      rsp_stale;

    // In-flight response is stale once a redirect or nuke is underway
    assign rsp_stale = redir.valid | nuke_pdg;

    always_comb begin
        state_nxt = state;
        case (state)
            FE_IDLE: state_nxt = FE_REQ_IC;
            // Hold off while decode cannot take another entry
            FE_REQ_IC: if (!full) state_nxt = FE_WAIT_RSP;
            FE_WAIT_RSP: state_nxt = nuke_pdg ? FE_PDG_NUKE : FE_REQ_IC;
            FE_PDG_NUKE: if (resume_fetch) state_nxt = FE_REQ_IC;
            default: state_nxt = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Memory request, one at a time
    always_comb begin
        req.valid = (state == FE_REQ_IC) & ~full;
        req.addr  = pc;
    end

    // Response lands exactly one cycle after the request
    assign push = (state == FE_WAIT_RSP) & rsp.valid & ~rsp_stale;

    always_comb begin
        push_data.instr = rsp.instr;
        push_data.pc    = rsp.pc;
    end

    // Redirect always takes priority over sequential advance
    always_comb begin
        if (redir.valid) begin
            pc_nxt = redir.target_addr;
        end else if (push) begin
            pc_nxt = pc + t_paddr'(4);
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FE_BOOT_VECTOR;
        end else begin
            pc <= pc_nxt;
        end
    end

endmodule

// File: src/fetch_buf.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fetch_buf
    import fe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  t_imem_wr imem_wr,
    input  t_fe_req  req,
    output t_fe_rsp  rsp
);

    localparam int IDX_W = $bits(t_imem_idx);

    t_instr    mem [`FE_IMEM_WORDS];
    t_imem_idx rd_idx;
    logic      rsp_valid;
    t_instr    rsp_instr;
    t_paddr    rsp_pc;

    // Word index, upper address bits ignored so it wraps
    assign rd_idx = req.addr[IDX_W+1:2];

    // Load port
    always_ff @(posedge clk) begin
        if (imem_wr.valid) begin
            mem[imem_wr.addr] <= imem_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
        end
    end

    // Read data and PC echo, one cycle after the request
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_instr <= mem[rd_idx];
            rsp_pc    <= req.addr;
        end
    end

    always_comb begin
        rsp.valid = rsp_valid;
        rsp.instr = rsp_instr;
        rsp.pc    = rsp_pc;
    end

endmodule

// File: src/instr_queue.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module instr_queue
    import fe_pkg::*;
#(
    parameter type T     = t_instr_pkt,
    parameter int  DEPTH = `FE_IQ_DEPTH
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic push,
    input  T     push_data,
    output logic full,
    input  logic pop,
    output logic valid,
    output T     head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Circular increment, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign valid = (count != '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = entries[rd_ptr];

    // Flush wins over a push or pop in the same cycle
    assign do_push = push & ~full & ~flush;
    assign do_pop  = pop & valid & ~flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

// File: src/fe_top.sv
`timescale 1ns/1ns

module fe_top
    import fe_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  t_imem_wr        imem_wr,
    input  t_br_mispred_pkt br_mispred,
    input  t_nuke_pkt       nuke,
    input  logic            resume_fetch,
    input  t_rob_id         oldest_robid,
    output logic            valid_de,
    output t_instr_pkt      instr_de,
    input  logic            decode_ready
);

    t_redirect  redir;
    logic       flush;
    logic       nuke_pdg;
    t_fe_req    req;
    t_fe_rsp    rsp;
    logic       push;
    t_instr_pkt push_data;
    logic       full;
    logic       pop;

    // Transfer to decode when both sides agree
    assign pop = valid_de & decode_ready;

    fe_redirect u_fe_redirect (
        .clk          (clk),
        .reset        (reset),
        .br_mispred   (br_mispred),
        .nuke         (nuke),
        .oldest_robid (oldest_robid),
        .redir        (redir),
        .flush        (flush),
        .nuke_pdg     (nuke_pdg)
    );

    fe_ctl u_fe_ctl (
        .clk          (clk),
        .reset        (reset),
        .redir        (redir),
        .nuke_pdg     (nuke_pdg),
        .resume_fetch (resume_fetch),
        .req          (req),
        .rsp          (rsp),
        .full         (full),
        .push         (push),
        .push_data    (push_data)
    );

    fetch_buf u_fetch_buf (
        .clk     (clk),
        .reset   (reset),
        .imem_wr (imem_wr),
        .req     (req),
        .rsp     (rsp)
    );

    instr_queue #(
        .T (t_instr_pkt)
    ) u_instr_queue (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .valid     (valid_de),
        .head      (instr_de)
    );

endmodule

// File: dv/fe_tb.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fe_tb
    import fe_pkg::*;
;

    localparam int RESET_CYCLES = 10;
    localparam int N_BOOT       = 8;
    localparam int N_RAND       = 40;
    localparam int N_REDIR      = 6;
    localparam int N_PRE_RESET  = 5;
    localparam int N_POST_RESET = 10;
    localparam int TOTAL_INSTR  = N_BOOT + N_RAND + 3 * N_REDIR + N_PRE_RESET + N_POST_RESET;
    // Worst case about 8 cycles per instruction plus idle and reset windows
    localparam int TEST_LEN     = `FE_IMEM_WORDS + 2 * RESET_CYCLES + 8 * TOTAL_INSTR + 120;
    localparam int MAX_CYCLES   = 2 * TEST_LEN + 100;

    logic            clk;
    logic            reset;
    t_imem_wr        imem_wr;
    t_br_mispred_pkt br_mispred;
    t_nuke_pkt       nuke;
    logic            resume_fetch;
    t_rob_id         oldest_robid;
    logic            valid_de;
    t_instr_pkt      instr_de;
    logic            decode_ready;

    t_instr model_mem [`FE_IMEM_WORDS];
    t_paddr exp_pc;
    integer seed = 32'h67d7_2ed3;
    int     errors;
    int     checks;
    int     cycles;

    fe_top u_fe_top (
        .clk          (clk),
        .reset        (reset),
        .imem_wr      (imem_wr),
        .br_mispred   (br_mispred),
        .nuke         (nuke),
        .resume_fetch (resume_fetch),
        .oldest_robid (oldest_robid),
        .valid_de     (valid_de),
        .instr_de     (instr_de),
        .decode_ready (decode_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic t_instr_pkt exp_pkt(t_paddr pc);
        t_instr_pkt p;
        // Word index is the byte address over 4 modulo the memory size
        p.instr = model_mem[t_imem_idx'(pc >> 2)];
        p.pc    = pc;
        return p;
    endfunction

    task automatic check_instr(input string name, input t_instr_pkt exp, input t_instr_pkt act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s: expected pc=%h instr=%h, got pc=%h instr=%h",
                     $time, name, exp.pc, exp.instr, act.pc, act.instr);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic load_memory();
        t_instr word;
        for (int i = 0; i < `FE_IMEM_WORDS; i++) begin
            @(negedge clk);
            word          = $random(seed);
            model_mem[i]  = word;
            imem_wr.valid = 1'b1;
            imem_wr.addr  = t_imem_idx'(i);
            imem_wr.data  = word;
        end
        @(negedge clk);
        imem_wr.valid = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset        = 1'b1;
        decode_ready = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_bit("valid_de", 1'b0, valid_de);
        end
        reset = 1'b0;
    endtask

    // Decode model that accepts n instructions in PC+4 order from exp_pc
    task automatic expect_stream(input int n, input logic random_ready);
        int          got;
        logic        ready;
        logic [31:0] rnd;
        logic        held;
        t_instr_pkt  held_pkt;
        got  = 0;
        held = 1'b0;
        while (got < n) begin
            @(negedge clk);
            // Head must not move while decode stalls
            if (held) begin
                check_bit("valid_de", 1'b1, valid_de);
                check_instr("instr_de", held_pkt, instr_de);
            end
            rnd          = $random(seed);
            ready        = random_ready ? rnd[0] : 1'b1;
            decode_ready = ready;
            if (valid_de && ready) begin
                check_instr("instr_de", exp_pkt(exp_pc), instr_de);
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            held     = valid_de & ~ready;
            held_pkt = instr_de;
        end
    endtask

    task automatic expect_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            decode_ready = 1'b1;
            check_bit("valid_de", 1'b0, valid_de);
        end
    endtask

    // Strobe plus one cycle for the flush to land while decode is stalled
    task automatic mispredict(input t_rob_id robid, input t_paddr target);
        @(negedge clk);
        br_mispred.valid       = 1'b1;
        br_mispred.robid       = robid;
        br_mispred.target_addr = target;
        decode_ready           = 1'b0;
        @(negedge clk);
        br_mispred.valid = 1'b0;
    endtask

    task automatic nuke_and_resume();
        @(negedge clk);
        nuke.valid = 1'b1;
        check_bit("valid_de", 1'b0, valid_de);
        @(negedge clk);
        nuke.valid = 1'b0;
        check_bit("valid_de", 1'b0, valid_de);
        expect_idle(4);
        @(negedge clk);
        resume_fetch = 1'b1;
        check_bit("valid_de", 1'b0, valid_de);
        @(negedge clk);
        resume_fetch = 1'b0;
    endtask

    task automatic test_boot();
        apply_reset();
        exp_pc = `FE_BOOT_VECTOR;
        expect_stream(N_BOOT, 1'b0);
    endtask

    task automatic test_backpressure();
        expect_stream(N_RAND, 1'b1);
    endtask

    task automatic test_mispredict();
        mispredict(5'd3, 32'h0000_0240);
        expect_idle(6);
        nuke_and_resume();
        exp_pc = 32'h0000_0240;
        expect_stream(N_REDIR, 1'b1);
    endtask

    task automatic test_oldest_wins();
        // Robid 31 is one entry from the oldest and robid 2 is four
        oldest_robid = 5'd30;
        mispredict(5'd2, 32'h0000_03c0);
        expect_idle(3);
        mispredict(5'd31, 32'h0000_0080);
        expect_idle(4);
        nuke_and_resume();
        exp_pc = 32'h0000_0080;
        expect_stream(N_REDIR, 1'b0);
        // Younger one second with a target that wraps the memory index
        mispredict(5'd31, 32'h0000_13f8);
        expect_idle(3);
        mispredict(5'd2, 32'h0000_0300);
        expect_idle(4);
        nuke_and_resume();
        exp_pc = 32'h0000_13f8;
        expect_stream(N_REDIR, 1'b1);
        oldest_robid = '0;
    endtask

    task automatic test_reset_midstream();
        expect_stream(N_PRE_RESET, 1'b1);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            decode_ready = 1'b0;
        end
        check_bit("valid_de", 1'b1, valid_de);
        apply_reset();
        exp_pc = `FE_BOOT_VECTOR;
        expect_stream(N_POST_RESET, 1'b1);
    endtask

    initial begin
        reset        = 1'b1;
        imem_wr      = '0;
        br_mispred   = '0;
        nuke         = '0;
        resume_fetch = 1'b0;
        oldest_robid = '0;
        decode_ready = 1'b0;
        exp_pc       = `FE_BOOT_VECTOR;
        errors       = 0;
        checks       = 0;
        load_memory();
        test_boot();
        test_backpressure();
        test_mispredict();
        test_oldest_wins();
        test_reset_midstream();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/fe_pkg.sv
src/fe_redirect.sv
fe/fe_ctl.sv
src/fetch_buf.sv
src/instr_queue.sv
src/fe_top.sv
dv/fe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module fe_tb -o fe_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/fe_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
